// ==== logic/cu_command_arbiter.sv ====
// round-robin merge of read and write engine commands into the burst buffer
`timescale 1ns/1ps

module cu_command_arbiter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [1:0]            req_valid,
	input  cu_pkg::cu_cmd_t [1:0] req_cmd,
	output logic [1:0]            req_ready,
	input  logic                  downstream_almost_full,
	output logic                  grant_valid,
	output cu_pkg::cu_cmd_t       grant_cmd
);

	logic last_grant;
	logic sel;

	// lone requester wins and a tie goes to the one not served last
	always_comb begin
		case (req_valid)
			2'b01:   sel = 1'b0;
			2'b10:   sel = 1'b1;
			default: sel = ~last_grant;
		endcase
	end

	// hold everything while the burst buffer is near full
	assign grant_valid  = (|req_valid) && !downstream_almost_full;
	assign grant_cmd    = req_cmd[sel];
	assign req_ready[0] = grant_valid && !sel;
	assign req_ready[1] = grant_valid && sel;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_grant <= 1'b1;
		end else if (grant_valid) begin
			last_grant <= sel;
		end
	end

	// an engine held back keeps offering the same command
	a_hold_read: assert property (@(posedge clock) disable iff (!rstn)
		req_valid[0] && !req_ready[0] |=> req_valid[0] && $stable(req_cmd[0]));
	a_hold_write: assert property (@(posedge clock) disable iff (!rstn)
		req_valid[1] && !req_ready[1] |=> req_valid[1] && $stable(req_cmd[1]));

endmodule

// ==== logic/cu_control.sv ====
// top level of the copy accelerator control unit wiring job control, engines and burst buffer
`timescale 1ns/1ps

module cu_control (
	input  logic            clock,
	input  logic            rstn,
	input  logic            job_valid,
	output logic            job_ready,
	input  cu_pkg::job_t    job,
	output logic            cmd_valid,
	input  logic            cmd_ready,
	output cu_pkg::cu_cmd_t cmd,
	input  logic            rsp_valid,
	input  cu_pkg::cu_rsp_t rsp,
	output cu_pkg::len_t    status,
	output logic            done
);

	logic                  start;
	cu_pkg::job_t          job_q;
	logic                  rd_line_valid;
	logic                  wr_rsp_valid;
	logic                  credit_return;
	logic [1:0]            req_valid;
	logic [1:0]            req_ready;
	cu_pkg::cu_cmd_t [1:0] req_cmd;
	logic                  grant_valid;
	cu_pkg::cu_cmd_t       grant_cmd;
	logic                  burst_empty;
	logic                  burst_almost_full;

	////////////////////////////////////////////////////////////////////////////
	// response routing by compute unit id
	////////////////////////////////////////////////////////////////////////////

	assign rd_line_valid = rsp_valid && (rsp.cu_id == cu_pkg::READ_ID);
	assign wr_rsp_valid  = rsp_valid && (rsp.cu_id == cu_pkg::WRITE_ID);

	cu_job_control job_control_i (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.job_valid   (job_valid   ),
		.job_ready   (job_ready   ),
		.job_in      (job         ),
		.start       (start       ),
		.job_out     (job_q       ),
		.wr_rsp_valid(wr_rsp_valid),
		.status      (status      ),
		.done        (done        )
	);

	////////////////////////////////////////////////////////////////////////////
	// engines in slot 0 (read) and slot 1 (write)
	////////////////////////////////////////////////////////////////////////////

	cu_read_engine read_engine_i (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.start        (start        ),
		.job          (job_q        ),
		.cmd_valid    (req_valid[0] ),
		.cmd_ready    (req_ready[0] ),
		.cmd          (req_cmd[0]   ),
		.credit_return(credit_return)
	);

	cu_write_engine write_engine_i (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.start        (start        ),
		.dst          (job_q.dst    ),
		.line_valid   (rd_line_valid),
		.line         (rsp          ),
		.cmd_valid    (req_valid[1] ),
		.cmd_ready    (req_ready[1] ),
		.cmd          (req_cmd[1]   ),
		.credit_return(credit_return)
	);

	cu_command_arbiter arbiter_i (
		.clock                 (clock            ),
		.rstn                  (rstn             ),
		.req_valid             (req_valid        ),
		.req_cmd               (req_cmd          ),
		.req_ready             (req_ready        ),
		.downstream_almost_full(burst_almost_full),
		.grant_valid           (grant_valid      ),
		.grant_cmd             (grant_cmd        )
	);

	////////////////////////////////////////////////////////////////////////////
	// burst command buffer toward the host
	////////////////////////////////////////////////////////////////////////////

	cu_fifo #(
		.WIDTH   ($bits(cu_pkg::cu_cmd_t)),
		.DEPTH   (cu_pkg::BURST_DEPTH    ),
		.HEADROOM(cu_pkg::BURST_HEADROOM )
	) burst_buf_i (
		.clock      (clock                 ),
		.rstn       (rstn                  ),
		.push       (grant_valid           ),
		.data_in    (grant_cmd             ),
		.pop        (cmd_valid && cmd_ready),
		.data_out   (cmd                   ),
		.empty      (burst_empty           ),
		.full       (                      ),
		.almost_full(burst_almost_full     )
	);

	assign cmd_valid = !burst_empty;

endmodule

// ==== logic/cu_fifo.sv ====
// synchronous circular buffer with occupancy count and almost-full headroom
`timescale 1ns/1ps

module cu_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);

	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	logic [WIDTH-1:0] mem [DEPTH];
	ptr_t             wr_ptr;
	ptr_t             rd_ptr;
	cnt_t             count;

	// storage array
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head word visible without a pop
	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign full        = (count == cnt_t'(DEPTH));
	assign almost_full = (count >= cnt_t'(DEPTH - HEADROOM));

	// upstream flow control must keep these from happening
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

// ==== logic/cu_job_control.sv ====
// job descriptor intake, write response count, status and done
`timescale 1ns/1ps

module cu_job_control (
	input  logic         clock,
	input  logic         rstn,
	input  logic         job_valid,
	output logic         job_ready,
	input  cu_pkg::job_t job_in,
	output logic         start,
	output cu_pkg::job_t job_out,
	input  logic         wr_rsp_valid,
	output cu_pkg::len_t status,
	output logic         done
);

	logic         active;
	logic         accept;
	cu_pkg::job_t job_q;
	cu_pkg::len_t count;

	assign job_ready = !active;
	assign accept    = job_valid && job_ready;

	// descriptor held for the engines
	always_ff @(posedge clock) begin
		if (accept) begin
			job_q <= job_in;
		end
	end

	assign job_out = job_q;
	assign status  = count;

	////////////////////////////////////////////////////////////////////////////
	// job state and response count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
			start  <= 1'b0;
			count  <= '0;
			done   <= 1'b0;
		end else begin
			// engines load the held descriptor in the cycle after acceptance
			start <= accept;
			if (accept) begin
				active <= 1'b1;
				count  <= '0;
				done   <= 1'b0;
			end else if (active && wr_rsp_valid) begin
				count <= count + 1'b1;
				// last write acknowledged
				if (count + 1'b1 == job_q.length) begin
					active <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/cu_pkg.sv ====
// shared constants and channel word types of the copy accelerator control unit
package cu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 64;
	localparam int LEN_W  = 8;

	// burst buffer toward the host
	localparam int BURST_DEPTH    = 16;
	localparam int BURST_HEADROOM = 4;

	// write engine line buffer depth and read credit limit
	localparam int DATA_BUF_DEPTH = 8;

	////////////////////////////////////////////////////////////////////////////
	// basic types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] line_t;
	typedef logic [LEN_W-1:0]  len_t;
	typedef logic              cu_id_t;

	// compute unit ids carried through the host and back
	localparam cu_id_t READ_ID  = 1'b0;
	localparam cu_id_t WRITE_ID = 1'b1;

	typedef enum logic {
		CMD_READ,
		CMD_WRITE
	} cmd_kind_t;

	////////////////////////////////////////////////////////////////////////////
	// channel words
	////////////////////////////////////////////////////////////////////////////

	// host command with zero data on reads
	typedef struct packed {
		cmd_kind_t kind;
		cu_id_t    cu_id;
		addr_t     addr;
		len_t      tag;
		line_t     data;
	} cu_cmd_t;

	// host response whose tag echoes the command
	typedef struct packed {
		cu_id_t cu_id;
		len_t   tag;
		line_t  data;
	} cu_rsp_t;

	typedef struct packed {
		addr_t src;
		addr_t dst;
		len_t  length;
	} job_t;

endpackage

// ==== logic/cu_read_engine.sv ====
// source read issue under a credit limit matching the write data buffer
`timescale 1ns/1ps

module cu_read_engine (
	input  logic            clock,
	input  logic            rstn,
	input  logic            start,
	input  cu_pkg::job_t    job,
	output logic            cmd_valid,
	input  logic            cmd_ready,
	output cu_pkg::cu_cmd_t cmd,
	input  logic            credit_return
);

	typedef logic [$clog2(cu_pkg::DATA_BUF_DEPTH+1)-1:0] credit_t;

	logic          active;
	cu_pkg::len_t  index;
	credit_t       credit;
	cu_pkg::addr_t src_q;
	cu_pkg::len_t  len_q;
	logic          issue;

	assign cmd_valid = active && (credit != '0);
	assign issue     = cmd_valid && cmd_ready;

	always_comb begin
		cmd       = '0;
		cmd.kind  = cu_pkg::CMD_READ;
		cmd.cu_id = cu_pkg::READ_ID;
		cmd.addr  = src_q + cu_pkg::addr_t'(index);
		cmd.tag   = index;
	end

	always_ff @(posedge clock) begin
		if (start) begin
			src_q <= job.src;
			len_q <= job.length;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
			index  <= '0;
			credit <= '0;
		end else if (start) begin
			active <= 1'b1;
			index  <= '0;
			credit <= credit_t'(cu_pkg::DATA_BUF_DEPTH);
		end else begin
			if (issue) begin
				index <= index + 1'b1;
				// last line handed out
				if (index == len_q - 1'b1) begin
					active <= 1'b0;
				end
			end
			case ({issue, credit_return})
				2'b10:   credit <= credit - 1'b1;
				2'b01:   credit <= credit + 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	// returns from the write engine never outrun what was issued
	a_credit_limit: assert property (@(posedge clock) disable iff (!rstn)
		credit <= credit_t'(cu_pkg::DATA_BUF_DEPTH));

endmodule

// ==== logic/cu_write_engine.sv ====
// buffers returned read lines and issues the matching destination writes
`timescale 1ns/1ps

module cu_write_engine (
	input  logic            clock,
	input  logic            rstn,
	input  logic            start,
	input  cu_pkg::addr_t   dst,
	input  logic            line_valid,
	input  cu_pkg::cu_rsp_t line,
	output logic            cmd_valid,
	input  logic            cmd_ready,
	output cu_pkg::cu_cmd_t cmd,
	output logic            credit_return
);

	cu_pkg::addr_t   dst_q;
	cu_pkg::cu_rsp_t head;
	logic            buf_empty;
	logic            pop;

	always_ff @(posedge clock) begin
		if (start) begin
			dst_q <= dst;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// line buffer
	////////////////////////////////////////////////////////////////////////////

	// read credit keeps this from ever filling
	cu_fifo #(
		.WIDTH   ($bits(cu_pkg::cu_rsp_t)),
		.DEPTH   (cu_pkg::DATA_BUF_DEPTH ),
		.HEADROOM(1                      )
	) data_buf_i (
		.clock      (clock     ),
		.rstn       (rstn      ),
		.push       (line_valid),
		.data_in    (line      ),
		.pop        (pop       ),
		.data_out   (head      ),
		.empty      (buf_empty ),
		.full       (          ),
		.almost_full(          )
	);

	////////////////////////////////////////////////////////////////////////////
	// write command from the head line
	////////////////////////////////////////////////////////////////////////////

	assign cmd_valid = !buf_empty;
	assign pop       = cmd_valid && cmd_ready;

	// one credit back per line leaving the buffer
	assign credit_return = pop;

	always_comb begin
		cmd       = '0;
		cmd.kind  = cu_pkg::CMD_WRITE;
		cmd.cu_id = cu_pkg::WRITE_ID;
		// tag is the line index within the job
		cmd.addr  = dst_q + cu_pkg::addr_t'(head.tag);
		cmd.tag   = head.tag;
		cmd.data  = head.data;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the control unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f sim.f --top-module cu_control_tb \
	-o cu_control_sim --Mdir obj_dir \
	&& { ./obj_dir/cu_control_sim > sim.log 2>&1 || true; } \
	&& ! grep -q ">>> FAIL" sim.log \
	&& grep -q ">>> PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
logic/cu_pkg.sv
logic/cu_fifo.sv
logic/cu_command_arbiter.sv
logic/cu_read_engine.sv
logic/cu_write_engine.sv
logic/cu_job_control.sv
logic/cu_control.sv
tb/cu_host_model.sv
tb/cu_control_tb.sv

// ==== tb/cu_control_tb.sv ====
// testbench for the copy accelerator control unit with job table, host model and copy checks
`timescale 1ns/1ps

module cu_control_tb;

	localparam int N_ROWS   = 6;
	localparam int CLK_HALF = 10;
	localparam int SEED     = 32'he28f5fc5;

	logic            clock;
	logic            rstn;
	logic            job_valid;
	logic            job_ready;
	cu_pkg::job_t    job;
	logic            cmd_valid;
	logic            cmd_ready;
	cu_pkg::cu_cmd_t cmd;
	logic            rsp_valid;
	cu_pkg::cu_rsp_t rsp;
	cu_pkg::len_t    status;
	logic            done;
	int              stall_pct;

	// job table
	string        name_tab  [N_ROWS];
	cu_pkg::job_t job_tab   [N_ROWS];
	int           stall_tab [N_ROWS];
	bit           chain_tab [N_ROWS];

	// command monitor state for the running job
	cu_pkg::job_t cur_job;
	string        cur_name;
	int           reads_seen;
	int           writes_seen;
	int           reads_before_write;

	cu_control dut_i (
		.clock    (clock    ),
		.rstn     (rstn     ),
		.job_valid(job_valid),
		.job_ready(job_ready),
		.job      (job      ),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd      (cmd      ),
		.rsp_valid(rsp_valid),
		.rsp      (rsp      ),
		.status   (status   ),
		.done     (done     )
	);

	cu_host_model #(
		.SEED(SEED)
	) host_i (
		.clock    (clock    ),
		.rstn     (rstn     ),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd      (cmd      ),
		.rsp_valid(rsp_valid),
		.rsp      (rsp      ),
		.stall_pct(stall_pct)
	);

	initial clock = 1'b0;
	always #(CLK_HALF) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// reference pattern and checks
	////////////////////////////////////////////////////////////////////////////

	function automatic cu_pkg::line_t source_line(input cu_pkg::addr_t addr);
		return {addr ^ 16'h5a3c, ~addr, addr * 16'd7 + 16'd3, addr};
	endfunction

	// offset from base taken modulo the address space
	function automatic bit in_range(input cu_pkg::addr_t addr, input cu_pkg::addr_t base,
			input cu_pkg::len_t length);
		return cu_pkg::addr_t'(addr - base) < cu_pkg::addr_t'(length);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_len(input string tname, input cu_pkg::len_t expected,
			input cu_pkg::len_t actual);
		if (expected !== actual) begin
			abort_run($sformatf("ERR %s expected %0d actual %0d", tname, expected, actual));
		end
	endtask

	task automatic check_line(input string tname, input cu_pkg::line_t expected,
			input cu_pkg::line_t actual);
		if (expected !== actual) begin
			abort_run($sformatf("ERR %s expected %016h actual %016h",
				tname, expected, actual));
		end
	endtask

	task automatic set_row(input int idx, input string tname, input cu_pkg::addr_t src,
			input cu_pkg::addr_t dst, input cu_pkg::len_t length, input int stall,
			input bit chain);
		name_tab[idx]   = tname;
		job_tab[idx]    = '{src: src, dst: dst, length: length};
		stall_tab[idx]  = stall;
		chain_tab[idx]  = chain;
	endtask

	task automatic load_jobs();
		set_row(0, "basic_16",   16'h0100, 16'h2000, 8'd16,  0,  1'b0);
		// chained rows are presented while the previous job still runs
		set_row(1, "chained_12", 16'h0300, 16'h2100, 8'd12,  10, 1'b1);
		set_row(2, "stall_60",   16'h0500, 16'h2200, 8'd20,  60, 1'b0);
		set_row(3, "single",     16'h0777, 16'h2300, 8'd1,   25, 1'b0);
		// source range wraps past the top of the address space
		set_row(4, "wrap_40",    16'hfff0, 16'h2400, 8'd40,  30, 1'b0);
		set_row(5, "chained_200", 16'h0900, 16'h3000, 8'd200, 40, 1'b1);
	endtask

	// commands seen on the host side of the burst buffer
	always @(negedge clock) begin
		if (rstn && cmd_valid && cmd_ready) begin
			if (cmd.kind == cu_pkg::CMD_READ) begin
				if (!in_range(cmd.addr, cur_job.src, cur_job.length)) begin
					abort_run($sformatf("read address %h outside the source range of %s",
						cmd.addr, cur_name));
				end
				reads_seen++;
			end else begin
				if (!in_range(cmd.addr, cur_job.dst, cur_job.length)) begin
					abort_run($sformatf("write address %h outside the destination range of %s",
						cmd.addr, cur_name));
				end
				if (writes_seen == 0) begin
					reads_before_write = reads_seen;
				end
				writes_seen++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// job handshake
	////////////////////////////////////////////////////////////////////////////

	task automatic present_job(input int r);
		job       = job_tab[r];
		job_valid = 1'b1;
	endtask

	task automatic accept_job(input int r);
		int waited;
		waited = 0;
		while (!job_ready) begin
			@(negedge clock);
			waited++;
		end
		if (chain_tab[r] && waited != 0) begin
			abort_run($sformatf("job %s was not accepted in the cycle after done", name_tab[r]));
		end
		@(posedge clock);
		#1;
		job_valid          = 1'b0;
		cur_job            = job_tab[r];
		cur_name           = name_tab[r];
		stall_pct          = stall_tab[r];
		reads_seen         = 0;
		writes_seen        = 0;
		reads_before_write = -1;
		if (done || job_ready) begin
			abort_run($sformatf("done or job_ready still high after %s was accepted", name_tab[r]));
		end
		check_len(name_tab[r], '0, status);
	endtask

	task automatic check_row(input int r);
		int i;
		check_len(name_tab[r], job_tab[r].length, status);
		if (!job_ready) begin
			abort_run($sformatf("job_ready stayed low after %s finished", name_tab[r]));
		end
		for (i = 0; i < int'(job_tab[r].length); i++) begin
			check_line(name_tab[r], source_line(cu_pkg::addr_t'(job_tab[r].src + i)),
				host_i.mem[cu_pkg::addr_t'(job_tab[r].dst + i)]);
		end
		if (reads_seen != int'(job_tab[r].length)
				|| writes_seen != int'(job_tab[r].length)) begin
			abort_run($sformatf("%s issued %0d reads and %0d writes for %0d lines",
				name_tab[r], reads_seen, writes_seen, job_tab[r].length));
		end
		// the credit limit forces a write ahead of the last reads
		if (job_tab[r].length > cu_pkg::DATA_BUF_DEPTH
				&& reads_before_write >= int'(job_tab[r].length)) begin
			abort_run($sformatf("no write command was interleaved with the reads of %s",
				name_tab[r]));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int r;
		bit presented;
		rstn               = 1'b0;
		job_valid          = 1'b0;
		job                = '0;
		stall_pct          = 0;
		cur_job            = '0;
		cur_name           = "reset";
		reads_seen         = 0;
		writes_seen        = 0;
		reads_before_write = -1;
		load_jobs();
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		check_len("reset", '0, status);
		if (!job_ready || done || cmd_valid) begin
			abort_run("outputs are not idle after reset");
		end
		presented = 1'b0;
		for (r = 0; r < N_ROWS; r++) begin
			if (!presented) begin
				@(posedge clock);
				#1;
				present_job(r);
			end
			accept_job(r);
			presented = 1'b0;
			if (r + 1 < N_ROWS && chain_tab[r + 1]) begin
				present_job(r + 1);
				presented = 1'b1;
			end
			do begin
				@(negedge clock);
			end while (!done);
			check_row(r);
		end
		$display(">>> PASS");
		$finish;
	end

	initial begin
		int limit;
		int k;
		wait (rstn === 1'b1);
		limit = 1000;
		for (k = 0; k < N_ROWS; k++) begin
			limit += int'(job_tab[k].length) * 40;
		end
		repeat (limit) @(posedge clock);
		abort_run("timeout: the run did not see done in time");
	end

endmodule

// ==== tb/cu_host_model.sv ====
// behavioural host memory that serves copy accelerator read and write commands
`timescale 1ns/1ps

module cu_host_model #(
	parameter int SEED = 0
) (
	input  logic            clock,
	input  logic            rstn,
	input  logic            cmd_valid,
	output logic            cmd_ready,
	input  cu_pkg::cu_cmd_t cmd,
	output logic            rsp_valid,
	output cu_pkg::cu_rsp_t rsp,
	input  int              stall_pct
);

	cu_pkg::line_t   mem [2**cu_pkg::ADDR_W];
	cu_pkg::cu_cmd_t pend_cmd [$];
	int              pend_due [$];
	cu_pkg::cu_cmd_t cur;
	int              cycle;
	int              seed;
	int              slot;
	int              a;
	int              i;

	// source pattern built from every address bit
	function automatic cu_pkg::line_t fill_line(input cu_pkg::addr_t addr);
		return {addr ^ 16'h5a3c, ~addr, addr * 16'd7 + 16'd3, addr};
	endfunction

	initial begin
		seed      = SEED;
		cycle     = 0;
		cmd_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp       = '0;
		for (a = 0; a < 2**cu_pkg::ADDR_W; a++) begin
			mem[cu_pkg::addr_t'(a)] = fill_line(cu_pkg::addr_t'(a));
		end
	end

	// handshake sampled mid-cycle ahead of its transfer edge
	always @(negedge clock) begin
		if (rstn && cmd_valid && cmd_ready) begin
			pend_cmd.push_back(cmd);
			pend_due.push_back(cycle + 1 + int'($random(seed) & 3));
		end
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		#1;
		rsp_valid = 1'b0;
		rsp       = '0;
		cmd_ready = rstn && (int'($unsigned($random(seed)) % 100) >= stall_pct);
		// first pending command whose delay ran out
		slot = -1;
		for (i = 0; i < pend_due.size(); i++) begin
			if (slot < 0 && pend_due[i] <= cycle) begin
				slot = i;
			end
		end
		if (slot >= 0) begin
			cur       = pend_cmd[slot];
			rsp_valid = 1'b1;
			rsp.cu_id = cur.cu_id;
			rsp.tag   = cur.tag;
			if (cur.kind == cu_pkg::CMD_READ) begin
				rsp.data = mem[cur.addr];
			end else begin
				mem[cur.addr] = cur.data;
			end
			pend_cmd.delete(slot);
			pend_due.delete(slot);
		end
	end

endmodule
